//--- rtl/soc_pkg.sv
package soc_pkg;

    // ##################################################
    // Memory map
    // ##################################################

    localparam int REGION_LSB = 30;           // Low bit of the two-bit region field.

    localparam logic [1:0] REGION_ROM   = 2'd0;
    localparam logic [1:0] REGION_RAM   = 2'd1;
    localparam logic [1:0] REGION_PORTS = 2'd3; // Region 2 is left unmapped.

    localparam int ROM_BITS = 4;              // 16 words, indexed by address bits 5..2.
    localparam int RAM_BITS = 10;             // 1k words, indexed by address bits 11..2.

    // ##################################################
    // Timing and pins
    // ##################################################

    localparam int TIMER_BITS         = 12;   // Interrupt period of 4096 cycles.
    localparam int RESET_DELAY_CYCLES = 64;   // Core reset hold time after reset release.
    localparam int PORT_IN_BITS       = 7;

    // ##################################################
    // Types
    // ##################################################

    typedef logic [31:0]           addr_t;
    typedef logic [31:0]           data_t;
    typedef logic [3:0]            byte_mask_t; // Bit i enables bits 8i+7..8i.
    typedef logic [1:0]            region_t;
    typedef logic [TIMER_BITS-1:0] timer_count_t;

    typedef enum logic [1:0] {
        st_hold,
        st_delay,
        st_run,
        st_fault
    } seq_state_t;

endpackage

//--- rtl/interval_timer.sv
`timescale 1ns/10ps

module interval_timer import soc_pkg::*; (
    input  logic cpu_clk,
    input  logic reset,
    input  logic irq_clear,
    output logic delay_done,
    output logic timer_irq
);

    localparam timer_count_t DELAY_LAST = timer_count_t'(RESET_DELAY_CYCLES - 1);
    localparam timer_count_t COUNT_LAST = '1;

    timer_count_t count;
    logic         delay_pending;                 // High until the first delay strobe.

    // ##################################################
    // Interval counter
    // ##################################################

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;               // Wraps freely.
        end
    end

    // The delay strobe fires once, in the first pass after reset.
    assign delay_done = delay_pending && (count == DELAY_LAST);

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            delay_pending <= 1'b1;
        end else if (delay_done) begin
            delay_pending <= 1'b0;
        end
    end

    // ##################################################
    // Timer interrupt
    // ##################################################

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            timer_irq <= 1'b0;
        end else if (count == COUNT_LAST) begin
            timer_irq <= 1'b1;                   // Set wins over a clear in the same cycle.
        end else if (irq_clear) begin
            timer_irq <= 1'b0;
        end
    end

endmodule

//--- rtl/reset_sequencer.sv
`timescale 1ns/10ps

module reset_sequencer import soc_pkg::*; (
    input  logic cpu_clk,
    input  logic reset,
    input  logic delay_done,
    input  logic bus_error,
    output logic core_reset,
    output logic error
);

    seq_state_t state;
    seq_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_hold:  state_next = st_delay;
            st_delay: if (delay_done) state_next = st_run;
            st_run:   if (bus_error) state_next = st_fault;
            st_fault: state_next = st_fault;   // Only an external reset leaves.
            default:  state_next = st_hold;
        endcase
    end

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            state      <= st_hold;
            core_reset <= 1'b0;
            error      <= 1'b0;
        end else begin
            state      <= state_next;
            core_reset <= (state_next == st_run);   // Core runs only in st_run.
            error      <= (state_next == st_fault);
        end
    end

endmodule

//--- rtl/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder import soc_pkg::*; (
    input  logic  cpu_clk,
    input  logic  reset,
    input  logic  ibus_cmd_valid,
    input  addr_t ibus_pc,
    output logic  ibus_rsp_error,
    output logic  rom_sel,
    input  logic  dbus_cmd_valid,
    input  logic  dbus_wr,
    input  addr_t dbus_addr,
    output logic  ram_sel,
    output logic  port_sel,
    input  data_t ram_rdata,
    input  data_t port_rdata,
    output data_t dbus_rsp_data,
    output logic  dbus_rsp_ready,
    output logic  dbus_rsp_error,
    output logic  bus_error
);

    region_t ibus_region;
    region_t dbus_region;
    logic    read_sel;
    logic    ram_read_q;                 // Last selected read went to RAM.

    assign ibus_region = ibus_pc[REGION_LSB +: $bits(region_t)];
    assign dbus_region = dbus_addr[REGION_LSB +: $bits(region_t)];

    assign rom_sel  = ibus_cmd_valid && (ibus_region == REGION_ROM);
    assign ram_sel  = dbus_cmd_valid && (dbus_region == REGION_RAM);
    assign port_sel = dbus_cmd_valid && (dbus_region == REGION_PORTS);
    assign read_sel = (ram_sel || port_sel) && !dbus_wr;

    // Errors are flagged in the same cycle as the command.
    assign ibus_rsp_error = ibus_cmd_valid && !rom_sel;
    assign dbus_rsp_error = dbus_cmd_valid && !(ram_sel || port_sel);
    assign bus_error      = ibus_rsp_error || dbus_rsp_error;

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            dbus_rsp_ready <= 1'b0;
            ram_read_q     <= 1'b0;
        end else begin
            dbus_rsp_ready <= read_sel;   // Read data is valid one cycle later.
            if (read_sel) begin
                ram_read_q <= ram_sel;
            end
        end
    end

    assign dbus_rsp_data = ram_read_q ? ram_rdata : port_rdata;

endmodule

//--- rtl/boot_rom.sv
`timescale 1ns/10ps

module boot_rom import soc_pkg::*; (
    input  logic  cpu_clk,
    input  logic  reset,
    input  logic  rom_sel,
    input  addr_t ibus_pc,
    output logic  ibus_rsp_valid,
    output data_t ibus_rsp_inst
);

    data_t rom_mem [0:(2**ROM_BITS)-1];

    initial begin
        $readmemh("rom_image.hex", rom_mem);
    end

    always_ff @(posedge cpu_clk) begin
        if (rom_sel) begin
            ibus_rsp_inst <= rom_mem[ibus_pc[ROM_BITS+1:2]];   // Word index.
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            ibus_rsp_valid <= 1'b0;
        end else begin
            ibus_rsp_valid <= rom_sel;
        end
    end

endmodule

//--- rtl/byte_ram.sv
`timescale 1ns/10ps

module byte_ram import soc_pkg::*; (
    input  logic       cpu_clk,
    input  logic       ram_sel,
    input  logic       dbus_wr,
    input  byte_mask_t dbus_mask,
    input  addr_t      dbus_addr,
    input  data_t      dbus_wdata,
    output data_t      ram_rdata
);

    localparam int LANES = $bits(byte_mask_t);

    logic [LANES-1:0][7:0] ram_mem [0:(2**RAM_BITS)-1];
    logic [RAM_BITS-1:0]   word_index;

    assign word_index = dbus_addr[RAM_BITS+1:2];

    // ##################################################
    // Byte-lane write and word read
    // ##################################################

    always_ff @(posedge cpu_clk) begin
        if (ram_sel) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (dbus_wr && dbus_mask[lane]) begin
                    ram_mem[word_index][lane] <= dbus_wdata[8*lane +: 8];
                end
            end
            ram_rdata <= ram_mem[word_index];   // Old contents on a write cycle.
        end
    end

endmodule

//--- rtl/port_block.sv
`timescale 1ns/10ps

module port_block import soc_pkg::*; (
    input  logic       cpu_clk,
    input  logic       reset,
    input  logic       port_sel,
    input  logic       dbus_wr,
    input  byte_mask_t dbus_mask,
    input  data_t      dbus_wdata,
    input  logic       con_button,
    input  logic       psh_button,
    input  logic       tra,
    input  logic       trb,
    input  logic       bak_button,
    input  logic       scl_in,
    input  logic       sda_in,
    output data_t      port_rdata,
    output logic       led,
    output logic       scl,
    output logic       sda,
    output logic       irq_clear
);

    logic [PORT_IN_BITS-1:0] pins;
    logic                    port_wr;

    assign pins    = {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in};
    assign port_wr = port_sel && dbus_wr;

    always_ff @(posedge cpu_clk) begin
        if (port_sel && !dbus_wr) begin
            port_rdata <= data_t'(pins);       // Zero above bit 6.
        end
    end

    // ##################################################
    // Output registers
    // ##################################################

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            led       <= 1'b1;
            scl       <= 1'b1;                 // I2C lines idle high.
            sda       <= 1'b1;
            irq_clear <= 1'b0;
        end else begin
            if (port_wr && dbus_mask[0]) begin
                {led, scl, sda} <= dbus_wdata[2:0];
            end
            irq_clear <= port_wr && dbus_mask[1] && dbus_wdata[8];   // One-cycle pulse.
        end
    end

endmodule

//--- rtl/soc_mem_subsys.sv
`timescale 1ns/10ps

module soc_mem_subsys import soc_pkg::*; (
    input  logic       cpu_clk,
    input  logic       reset,
    input  logic       ibus_cmd_valid,
    input  addr_t      ibus_pc,
    output logic       ibus_rsp_valid,
    output data_t      ibus_rsp_inst,
    output logic       ibus_rsp_error,
    input  logic       dbus_cmd_valid,
    input  logic       dbus_wr,
    input  byte_mask_t dbus_mask,
    input  addr_t      dbus_addr,
    input  data_t      dbus_wdata,
    output logic       dbus_rsp_ready,
    output logic       dbus_rsp_error,
    output data_t      dbus_rsp_data,
    input  logic       con_button,
    input  logic       psh_button,
    input  logic       tra,
    input  logic       trb,
    input  logic       bak_button,
    input  logic       scl_in,
    input  logic       sda_in,
    output logic       led,
    output logic       scl,
    output logic       sda,
    output logic       timer_irq,
    output logic       core_reset,
    output logic       error
);

    logic  rom_sel;
    logic  ram_sel;
    logic  port_sel;
    data_t ram_rdata;
    data_t port_rdata;
    logic  bus_error;
    logic  delay_done;
    logic  irq_clear;

    // ##################################################
    // Control blocks
    // ##################################################

    interval_timer u_timer (
        .cpu_clk    (cpu_clk),
        .reset      (reset),
        .irq_clear  (irq_clear),
        .delay_done (delay_done),
        .timer_irq  (timer_irq)
    );

    reset_sequencer u_sequencer (
        .cpu_clk    (cpu_clk),
        .reset      (reset),
        .delay_done (delay_done),
        .bus_error  (bus_error),
        .core_reset (core_reset),
        .error      (error)
    );

    bus_decoder u_decoder (
        .cpu_clk        (cpu_clk),
        .reset          (reset),
        .ibus_cmd_valid (ibus_cmd_valid),
        .ibus_pc        (ibus_pc),
        .ibus_rsp_error (ibus_rsp_error),
        .rom_sel        (rom_sel),
        .dbus_cmd_valid (dbus_cmd_valid),
        .dbus_wr        (dbus_wr),
        .dbus_addr      (dbus_addr),
        .ram_sel        (ram_sel),
        .port_sel       (port_sel),
        .ram_rdata      (ram_rdata),
        .port_rdata     (port_rdata),
        .dbus_rsp_data  (dbus_rsp_data),
        .dbus_rsp_ready (dbus_rsp_ready),
        .dbus_rsp_error (dbus_rsp_error),
        .bus_error      (bus_error)
    );

    // ##################################################
    // Memories and ports
    // ##################################################

    boot_rom u_rom (
        .cpu_clk        (cpu_clk),
        .reset          (reset),
        .rom_sel        (rom_sel),
        .ibus_pc        (ibus_pc),
        .ibus_rsp_valid (ibus_rsp_valid),
        .ibus_rsp_inst  (ibus_rsp_inst)
    );

    byte_ram u_ram (
        .cpu_clk    (cpu_clk),
        .ram_sel    (ram_sel),
        .dbus_wr    (dbus_wr),
        .dbus_mask  (dbus_mask),
        .dbus_addr  (dbus_addr),
        .dbus_wdata (dbus_wdata),
        .ram_rdata  (ram_rdata)
    );

    port_block u_ports (
        .cpu_clk    (cpu_clk),
        .reset      (reset),
        .port_sel   (port_sel),
        .dbus_wr    (dbus_wr),
        .dbus_mask  (dbus_mask),
        .dbus_wdata (dbus_wdata),
        .con_button (con_button),
        .psh_button (psh_button),
        .tra        (tra),
        .trb        (trb),
        .bak_button (bak_button),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .port_rdata (port_rdata),
        .led        (led),
        .scl        (scl),
        .sda        (sda),
        .irq_clear  (irq_clear)
    );

endmodule

//--- tb/tb_soc_mem_subsys.sv
`timescale 1ns/10ps

module tb_soc_mem_subsys import soc_pkg::*; ();

    localparam int RESET_CYCLES   = 8;
    localparam int RAM_WORDS      = 32;
    localparam int RANDOM_OPS     = 3000;
    localparam int IRQ_PERIOD     = 2**TIMER_BITS;
    localparam int TIMEOUT_CYCLES = 20000;   // Delay, two periods and the random ops, with margin.

    logic       cpu_clk;
    logic       reset;
    logic       ibus_cmd_valid, ibus_rsp_valid, ibus_rsp_error;
    addr_t      ibus_pc;
    data_t      ibus_rsp_inst;
    logic       dbus_cmd_valid, dbus_wr, dbus_rsp_ready, dbus_rsp_error;
    byte_mask_t dbus_mask;
    addr_t      dbus_addr;
    data_t      dbus_wdata, dbus_rsp_data;
    logic       con_button, psh_button, tra, trb, bak_button, scl_in, sda_in;
    logic       led, scl, sda, timer_irq, core_reset, error;

    integer seed          = 40;
    int     cycle_count   = 0;
    int     release_edges = 0;                // Edges seen since reset went high.
    logic   clear_model;
    logic   irq_model;
    logic   led_model, scl_model, sda_model;
    data_t  rom_model [0:(2**ROM_BITS)-1];
    data_t  ram_model [0:RAM_WORDS-1];

    soc_mem_subsys DUT (.*);

    initial begin
        cpu_clk = 1'b0;
        forever #4 cpu_clk = ~cpu_clk;
    end

    // ##################################################
    // Interrupt model and run limit
    // ##################################################

    always @(posedge cpu_clk) begin
        if (!reset) begin
            release_edges <= 0;
            clear_model   <= 1'b0;
            irq_model     <= 1'b0;
        end else begin
            release_edges <= release_edges + 1;
            clear_model   <= dbus_cmd_valid && dbus_wr && dbus_mask[1] && dbus_wdata[8]
                             && (dbus_addr[REGION_LSB +: 2] == REGION_PORTS);
            if ((release_edges + 1) % IRQ_PERIOD == 0) begin
                irq_model <= 1'b1;
            end else if (clear_model) begin
                irq_model <= 1'b0;
            end
        end
    end

    always @(negedge cpu_clk) begin
        check_bit("timer_irq", timer_irq, irq_model);
    end

    always @(posedge cpu_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the run did not finish in %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    // ##################################################
    // Compare tasks
    // ##################################################

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t act, input data_t exp);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: got %h, expected %h", name, act, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: got %h, expected %h", name, act, exp));
        end
    endtask

    task automatic check_state(input logic rst_act, input logic err_act,
                               input logic rst_exp, input logic err_exp);
        if ({rst_act, err_act} !== {rst_exp, err_exp}) begin
            report_failure($sformatf("ERROR core_reset/error: got %h/%h, expected %h/%h",
                                     rst_act, err_act, rst_exp, err_exp));
        end
    endtask

    function automatic data_t merge_bytes(input data_t old, input data_t wdata,
                                          input byte_mask_t mask);
        data_t merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) merged[8*b +: 8] = wdata[8*b +: 8];
        end
        return merged;
    endfunction

    // ##################################################
    // Bus driving
    // ##################################################

    task automatic drive_idle();
        ibus_cmd_valid <= 1'b0;
        dbus_cmd_valid <= 1'b0;
        dbus_wr        <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge cpu_clk);
        reset <= 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge cpu_clk);
        reset <= 1'b1;
        {led_model, scl_model, sda_model} = 3'b111;
        @(negedge cpu_clk);
        check_state(core_reset, error, 1'b0, 1'b0);
        check_bit("ibus_rsp_valid", ibus_rsp_valid, 1'b0);
        check_bit("dbus_rsp_ready", dbus_rsp_ready, 1'b0);
        check_bit("irq_clear", DUT.irq_clear, 1'b0);
        check_bit("led", led, 1'b1);
        check_bit("scl", scl, 1'b1);
        check_bit("sda", sda, 1'b1);
        for (int i = 1; i < RESET_DELAY_CYCLES; i++) begin
            @(negedge cpu_clk);
            check_state(core_reset, error, 1'b0, 1'b0);
        end
        @(negedge cpu_clk);
        check_state(core_reset, error, 1'b1, 1'b0);   // Core released on edge 64.
    endtask

    task automatic fetch_rom(input logic [ROM_BITS-1:0] index);
        @(posedge cpu_clk);
        ibus_cmd_valid <= 1'b1;
        ibus_pc        <= {REGION_ROM, {(28-ROM_BITS){1'b0}}, index, 2'b00};
        @(negedge cpu_clk);
        check_bit("ibus_rsp_error", ibus_rsp_error, 1'b0);
        @(posedge cpu_clk);
        drive_idle();
        @(negedge cpu_clk);
        check_bit("ibus_rsp_valid", ibus_rsp_valid, 1'b1);
        check_data("ibus_rsp_inst", ibus_rsp_inst, rom_model[index]);
    endtask

    // A fetch outside the ROM region faults the core on the next edge.
    task automatic fetch_unmapped(input addr_t pc);
        @(posedge cpu_clk);
        ibus_cmd_valid <= 1'b1;
        ibus_pc        <= pc;
        @(negedge cpu_clk);
        check_bit("ibus_rsp_error", ibus_rsp_error, 1'b1);
        @(posedge cpu_clk);
        drive_idle();
        @(negedge cpu_clk);
        check_bit("ibus_rsp_valid", ibus_rsp_valid, 1'b0);
        check_state(core_reset, error, 1'b0, 1'b1);
    endtask

    // One data command, with the error flag checked in its own cycle.
    task automatic issue_data(input addr_t addr, input logic wr, input byte_mask_t mask,
                              input data_t wdata, input logic err_exp);
        @(posedge cpu_clk);
        dbus_cmd_valid <= 1'b1;
        dbus_wr        <= wr;
        dbus_mask      <= mask;
        dbus_addr      <= addr;
        dbus_wdata     <= wdata;
        @(negedge cpu_clk);
        check_bit("dbus_rsp_error", dbus_rsp_error, err_exp);
        @(posedge cpu_clk);
        drive_idle();
        @(negedge cpu_clk);
    endtask

    task automatic write_ram(input logic [4:0] index, input byte_mask_t mask,
                             input data_t wdata);
        issue_data({REGION_RAM, 18'h0, 5'h0, index, 2'b00}, 1'b1, mask, wdata, 1'b0);
        ram_model[index] = merge_bytes(ram_model[index], wdata, mask);
        check_bit("dbus_rsp_ready", dbus_rsp_ready, 1'b0);
    endtask

    task automatic read_ram(input logic [4:0] index);
        issue_data({REGION_RAM, 18'h0, 5'h0, index, 2'b00}, 1'b0, 4'h0, 32'h0, 1'b0);
        check_bit("dbus_rsp_ready", dbus_rsp_ready, 1'b1);
        check_data("dbus_rsp_data", dbus_rsp_data, ram_model[index]);
    endtask

    task automatic access_ports(input logic wr, input byte_mask_t mask, input data_t wdata,
                                input logic [PORT_IN_BITS-1:0] pins);
        @(posedge cpu_clk);
        {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in} <= pins;
        issue_data({REGION_PORTS, 30'h0}, wr, mask, wdata, 1'b0);
        if (wr) begin
            if (mask[0]) {led_model, scl_model, sda_model} = wdata[2:0];
            check_bit("dbus_rsp_ready", dbus_rsp_ready, 1'b0);
        end else begin
            check_bit("dbus_rsp_ready", dbus_rsp_ready, 1'b1);
            check_data("dbus_rsp_data", dbus_rsp_data, data_t'(pins));
        end
        check_bit("led", led, led_model);
        check_bit("scl", scl, scl_model);
        check_bit("sda", sda, sda_model);
    endtask

    // ##################################################
    // Test sequence
    // ##################################################

    initial begin
        data_t rnd;
        data_t wdata;
        $readmemh("rom_image.hex", rom_model);
        reset          = 1'b0;
        ibus_cmd_valid = 1'b0;
        ibus_pc        = '0;
        dbus_cmd_valid = 1'b0;
        dbus_wr        = 1'b0;
        dbus_mask      = '0;
        dbus_addr      = '0;
        dbus_wdata     = '0;
        {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in} = '0;
        apply_reset();
        for (int w = 0; w < RAM_WORDS; w++) begin
            write_ram(w[4:0], 4'hf, $random(seed));
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            case (rnd[1:0])
                2'd0: fetch_rom(rnd[5:2]);
                2'd1: write_ram(rnd[10:6], rnd[14:11], wdata);
                2'd2: read_ram(rnd[10:6]);
                default: access_ports(rnd[15], rnd[19:16], wdata, rnd[26:20]);
            endcase
            check_state(core_reset, error, 1'b1, 1'b0);
        end
        access_ports(1'b1, 4'b0010, 32'h100, 7'h0);      // Clear a pending interrupt.
        @(negedge cpu_clk);
        while ((release_edges % IRQ_PERIOD) != IRQ_PERIOD - 1) @(negedge cpu_clk);
        check_bit("timer_irq", timer_irq, 1'b0);
        @(negedge cpu_clk);
        check_bit("timer_irq", timer_irq, 1'b1);
        access_ports(1'b1, 4'b0010, 32'h100, 7'h0);
        check_bit("timer_irq", timer_irq, 1'b1);         // Pulse is applied one edge later.
        @(negedge cpu_clk);
        check_bit("timer_irq", timer_irq, 1'b0);
        rnd = $random(seed);
        issue_data({2'd2, rnd[29:0]}, rnd[30], rnd[3:0], $random(seed), 1'b1);
        repeat (4) begin
            check_state(core_reset, error, 1'b0, 1'b1);
            @(negedge cpu_clk);
        end
        apply_reset();
        rnd = $random(seed);
        fetch_unmapped({REGION_RAM, rnd[29:0]});
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- rom_image.hex
// Boot ROM image: one 32-bit instruction word per line, in hex.
// Lines map to ROM word addresses 0 to 15 in order.
00000093
00100113
400001b7
c0000237
0001a283
00128293
0051a023
00022303
00737313
00622023
10000393
00722023
fe000ee3
0000006f
00000013
00000013

//--- soc_mem_subsys.f
rtl/soc_pkg.sv
rtl/interval_timer.sv
rtl/reset_sequencer.sv
rtl/bus_decoder.sv
rtl/boot_rom.sv
rtl/byte_ram.sv
rtl/port_block.sv
rtl/soc_mem_subsys.sv
tb/tb_soc_mem_subsys.sv
